// ==== hw/cache_pkg.sv ====
// shared by both caches; word-aligned byte addresses, 4-word lines, 64 lines per cache
package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // line geometry
    localparam int OFFSET_W       = 2;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int I_INDEX_W      = 6;
    localparam int D_INDEX_W      = 6;

    // operation carried on each pipeline request
    typedef enum logic [1:0] {
        MEM_OP_READ  = 2'd0,
        MEM_OP_WRITE = 2'd1,
        MEM_OP_INVAL = 2'd2
    } mem_op_e;

    // cache controller
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_REFILL = 2'd1,   // four single-word reads
        ST_WRITE  = 2'd2,   // one strobed write
        ST_RESP   = 2'd3
    } cache_state_e;

endpackage

// ==== hw/icache.sv ====
// read-only and direct-mapped; any op other than MEM_OP_INVAL is treated as a read
module icache (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         req_valid_i,
    input  cache_pkg::mem_op_e           req_op_i,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    output logic                         req_ready_o,
    output logic                         resp_valid_o,
    output logic [cache_pkg::DATA_W-1:0] rdata_o,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic [cache_pkg::ADDR_W-1:0] wb_adr_o,
    input  logic                         wb_ack_i,
    input  logic [cache_pkg::DATA_W-1:0] wb_dat_i
);
    import cache_pkg::*;

    localparam int TAG_W = ADDR_W - I_INDEX_W - OFFSET_W - 2;
    localparam int LINES = 1 << I_INDEX_W;

    cache_state_e        state_q;
    logic [OFFSET_W-1:0] cnt_q;     // word being refilled
    logic                gap_q;     // stb low between words
    logic [LINES-1:0]    valid_q;
    logic [TAG_W-1:0]    tag_mem  [LINES];
    logic [DATA_W-1:0]   data_mem [LINES*WORDS_PER_LINE];
    logic [ADDR_W-3:0]   word_q;    // word address of the request in flight
    logic [DATA_W-1:0]   rdata_q;

    logic [TAG_W-1:0]     req_tag;
    logic [I_INDEX_W-1:0] req_idx;
    logic [OFFSET_W-1:0]  req_off;
    logic [TAG_W-1:0]     tag_q;
    logic [I_INDEX_W-1:0] idx_q;
    logic [OFFSET_W-1:0]  off_q;
    logic                 accept;
    logic                 is_inval;
    logic                 hit;
    logic                 word_ack;

    assign req_tag = addr_i[ADDR_W-1 -: TAG_W];
    assign req_idx = addr_i[OFFSET_W+2 +: I_INDEX_W];
    assign req_off = addr_i[2 +: OFFSET_W];
    assign tag_q   = word_q[ADDR_W-3 -: TAG_W];
    assign idx_q   = word_q[OFFSET_W +: I_INDEX_W];
    assign off_q   = word_q[OFFSET_W-1:0];

    assign accept   = req_valid_i && req_ready_o;
    assign is_inval = (req_op_i == MEM_OP_INVAL);
    assign hit      = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign word_ack = wb_stb_o && wb_ack_i;

    assign req_ready_o  = (state_q == ST_IDLE);
    assign resp_valid_o = (state_q == ST_RESP);
    assign rdata_o      = rdata_q;
    assign wb_cyc_o     = (state_q == ST_REFILL);   // held across all four words
    assign wb_stb_o     = wb_cyc_o && !gap_q;
    assign wb_adr_o     = {tag_q, idx_q, cnt_q, 2'b00};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            gap_q   <= 1'b0;
            valid_q <= '0;
        end else begin
            gap_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        cnt_q <= '0;
                        if (is_inval) begin
                            valid_q[req_idx] <= 1'b0;   // tag not checked
                            state_q          <= ST_RESP;
                        end else if (hit) begin
                            state_q <= ST_RESP;
                        end else begin
                            state_q <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL: begin
                    if (word_ack) begin
                        cnt_q <= cnt_q + 1'b1;
                        gap_q <= 1'b1;
                        if (cnt_q == '1) begin
                            valid_q[idx_q] <= 1'b1;
                            state_q        <= ST_RESP;
                        end
                    end
                end
                default: state_q <= ST_IDLE;   // ST_RESP lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q  <= addr_i[ADDR_W-1:2];
            rdata_q <= is_inval ? '0 : data_mem[{req_idx, req_off}];
        end
        if (word_ack) begin
            data_mem[{idx_q, cnt_q}] <= wb_dat_i;
            if (cnt_q == off_q) rdata_q <= wb_dat_i;   // requested word
            if (cnt_q == '1) tag_mem[idx_q] <= tag_q;
        end
    end

endmodule

// ==== hw/dcache.sv ====
// direct-mapped, write-through, no write allocate; coherence with the icache is not handled
module dcache (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             req_valid_i,
    input  cache_pkg::mem_op_e               req_op_i,
    input  logic [cache_pkg::ADDR_W-1:0]     addr_i,
    input  logic [cache_pkg::DATA_W-1:0]     wdata_i,
    input  logic [cache_pkg::DATA_W/8-1:0]   wstrb_i,
    output logic                             req_ready_o,
    output logic                             resp_valid_o,
    output logic [cache_pkg::DATA_W-1:0]     rdata_o,
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [cache_pkg::ADDR_W-1:0]     wb_adr_o,
    output logic [cache_pkg::DATA_W-1:0]     wb_dat_o,
    output logic [cache_pkg::DATA_W/8-1:0]   wb_sel_o,
    input  logic                             wb_ack_i,
    input  logic [cache_pkg::DATA_W-1:0]     wb_dat_i
);
    import cache_pkg::*;

    localparam int TAG_W  = ADDR_W - D_INDEX_W - OFFSET_W - 2;
    localparam int LINES  = 1 << D_INDEX_W;
    localparam int STRB_W = DATA_W / 8;

    cache_state_e        state_q;
    logic [OFFSET_W-1:0] cnt_q;
    logic                gap_q;
    logic [LINES-1:0]    valid_q;
    logic [TAG_W-1:0]    tag_mem  [LINES];
    logic [DATA_W-1:0]   data_mem [LINES*WORDS_PER_LINE];
    logic [ADDR_W-3:0]   word_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [STRB_W-1:0]   wstrb_q;
    logic [DATA_W-1:0]   rdata_q;

    logic [TAG_W-1:0]     req_tag;
    logic [D_INDEX_W-1:0] req_idx;
    logic [OFFSET_W-1:0]  req_off;
    logic [TAG_W-1:0]     tag_q;
    logic [D_INDEX_W-1:0] idx_q;
    logic [OFFSET_W-1:0]  off_q;
    logic                 accept;
    logic                 is_read;
    logic                 hit;
    logic                 wr_hit;
    logic                 refill_ack;
    logic                 write_ack;

    assign req_tag = addr_i[ADDR_W-1 -: TAG_W];
    assign req_idx = addr_i[OFFSET_W+2 +: D_INDEX_W];
    assign req_off = addr_i[2 +: OFFSET_W];
    assign tag_q   = word_q[ADDR_W-3 -: TAG_W];
    assign idx_q   = word_q[OFFSET_W +: D_INDEX_W];
    assign off_q   = word_q[OFFSET_W-1:0];

    assign accept     = req_valid_i && req_ready_o;
    assign is_read    = (req_op_i != MEM_OP_WRITE) && (req_op_i != MEM_OP_INVAL);
    assign hit        = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign wr_hit     = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);
    assign refill_ack = wb_stb_o && wb_ack_i && (state_q == ST_REFILL);
    assign write_ack  = wb_stb_o && wb_ack_i && (state_q == ST_WRITE);

    assign req_ready_o  = (state_q == ST_IDLE);
    assign resp_valid_o = (state_q == ST_RESP);
    assign rdata_o      = rdata_q;
    assign wb_cyc_o     = (state_q == ST_REFILL) || (state_q == ST_WRITE);
    assign wb_stb_o     = wb_cyc_o && !gap_q;
    assign wb_we_o      = (state_q == ST_WRITE);
    assign wb_adr_o     = {tag_q, idx_q, wb_we_o ? off_q : cnt_q, 2'b00};
    assign wb_dat_o     = wdata_q;
    assign wb_sel_o     = wstrb_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            gap_q   <= 1'b0;
            valid_q <= '0;
        end else begin
            gap_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        cnt_q <= '0;
                        if (req_op_i == MEM_OP_INVAL) begin
                            valid_q[req_idx] <= 1'b0;
                            state_q          <= ST_RESP;
                        end else if (req_op_i == MEM_OP_WRITE) begin
                            state_q <= ST_WRITE;    // always goes to the bus
                        end else if (hit) begin
                            state_q <= ST_RESP;
                        end else begin
                            state_q <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL: begin
                    if (refill_ack) begin
                        cnt_q <= cnt_q + 1'b1;
                        gap_q <= 1'b1;
                        if (cnt_q == '1) begin
                            valid_q[idx_q] <= 1'b1;
                            state_q        <= ST_RESP;
                        end
                    end
                end
                ST_WRITE: if (write_ack) state_q <= ST_RESP;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q  <= addr_i[ADDR_W-1:2];
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
            rdata_q <= is_read ? data_mem[{req_idx, req_off}] : '0;
        end
        if (refill_ack) begin
            data_mem[{idx_q, cnt_q}] <= wb_dat_i;
            if (cnt_q == off_q) rdata_q <= wb_dat_i;
            if (cnt_q == '1) tag_mem[idx_q] <= tag_q;
        end
        // merge into the line only on a hit, miss leaves the cache alone
        if (write_ack && wr_hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_q[b]) data_mem[{idx_q, off_q}][8*b +: 8] <= wdata_q[8*b +: 8];
            end
        end
    end

endmodule

// ==== hw/wb_arbiter.sv ====
// two Wishbone classic masters; slave must ack only while cyc and stb are high
module wb_arbiter (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             m0_cyc_i,
    input  logic                             m0_stb_i,
    input  logic                             m0_we_i,
    input  logic [cache_pkg::ADDR_W-1:0]     m0_adr_i,
    input  logic [cache_pkg::DATA_W-1:0]     m0_dat_i,
    input  logic [cache_pkg::DATA_W/8-1:0]   m0_sel_i,
    output logic                             m0_ack_o,
    output logic [cache_pkg::DATA_W-1:0]     m0_dat_o,
    input  logic                             m1_cyc_i,
    input  logic                             m1_stb_i,
    input  logic                             m1_we_i,
    input  logic [cache_pkg::ADDR_W-1:0]     m1_adr_i,
    input  logic [cache_pkg::DATA_W-1:0]     m1_dat_i,
    input  logic [cache_pkg::DATA_W/8-1:0]   m1_sel_i,
    output logic                             m1_ack_o,
    output logic [cache_pkg::DATA_W-1:0]     m1_dat_o,
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [cache_pkg::ADDR_W-1:0]     wb_adr_o,
    output logic [cache_pkg::DATA_W-1:0]     wb_dat_o,
    output logic [cache_pkg::DATA_W/8-1:0]   wb_sel_o,
    input  logic                             wb_ack_i,
    input  logic [cache_pkg::DATA_W-1:0]     wb_dat_i
);
    logic busy_q;   // owner still holds cyc
    logic owner_q;  // 0 is m0
    logic last_q;   // winner of the latest new grant
    logic grant;

    // same-cycle grant when the bus is free
    always_comb begin
        if (busy_q) grant = owner_q;
        else if (m0_cyc_i && m1_cyc_i) grant = !last_q;   // tie alternates
        else grant = m1_cyc_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            last_q  <= 1'b1;    // so m0 takes the first tie
        end else begin
            busy_q  <= grant ? m1_cyc_i : m0_cyc_i;
            owner_q <= grant;
            if (!busy_q && (m0_cyc_i || m1_cyc_i)) last_q <= grant;
        end
    end

    assign wb_cyc_o = grant ? m1_cyc_i : m0_cyc_i;
    assign wb_stb_o = grant ? m1_stb_i : m0_stb_i;
    assign wb_we_o  = grant ? m1_we_i  : m0_we_i;
    assign wb_adr_o = grant ? m1_adr_i : m0_adr_i;
    assign wb_dat_o = grant ? m1_dat_i : m0_dat_i;
    assign wb_sel_o = grant ? m1_sel_i : m0_sel_i;

    assign m0_ack_o = wb_ack_i && !grant && m0_cyc_i;   // waiting master sees nothing
    assign m1_ack_o = wb_ack_i && grant && m1_cyc_i;
    assign m0_dat_o = grant ? '0 : wb_dat_i;
    assign m1_dat_o = grant ? wb_dat_i : '0;

endmodule

// ==== hw/cache_top.sv ====
// i and d caches share one bus; fetch and data addresses must not overlap
module cache_top (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             i_req_valid_i,
    input  cache_pkg::mem_op_e               i_req_op_i,
    input  logic [cache_pkg::ADDR_W-1:0]     i_addr_i,
    output logic                             i_req_ready_o,
    output logic                             i_resp_valid_o,
    output logic [cache_pkg::DATA_W-1:0]     i_rdata_o,
    input  logic                             d_req_valid_i,
    input  cache_pkg::mem_op_e               d_req_op_i,
    input  logic [cache_pkg::ADDR_W-1:0]     d_addr_i,
    input  logic [cache_pkg::DATA_W-1:0]     d_wdata_i,
    input  logic [cache_pkg::DATA_W/8-1:0]   d_wstrb_i,
    output logic                             d_req_ready_o,
    output logic                             d_resp_valid_o,
    output logic [cache_pkg::DATA_W-1:0]     d_rdata_o,
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [cache_pkg::ADDR_W-1:0]     wb_adr_o,
    output logic [cache_pkg::DATA_W-1:0]     wb_dat_o,
    output logic [cache_pkg::DATA_W/8-1:0]   wb_sel_o,
    input  logic                             wb_ack_i,
    input  logic [cache_pkg::DATA_W-1:0]     wb_dat_i
);
    import cache_pkg::*;

    logic                ic_cyc, ic_stb, ic_ack;
    logic [ADDR_W-1:0]   ic_adr;
    logic [DATA_W-1:0]   ic_dat_r;
    logic                dc_cyc, dc_stb, dc_we, dc_ack;
    logic [ADDR_W-1:0]   dc_adr;
    logic [DATA_W-1:0]   dc_dat_w, dc_dat_r;
    logic [DATA_W/8-1:0] dc_sel;

    icache u_icache (
        .clk, .reset_i,
        .req_valid_i(i_req_valid_i), .req_op_i(i_req_op_i), .addr_i(i_addr_i),
        .req_ready_o(i_req_ready_o), .resp_valid_o(i_resp_valid_o), .rdata_o(i_rdata_o),
        .wb_cyc_o(ic_cyc), .wb_stb_o(ic_stb), .wb_adr_o(ic_adr),
        .wb_ack_i(ic_ack), .wb_dat_i(ic_dat_r)
    );

    dcache u_dcache (
        .clk, .reset_i,
        .req_valid_i(d_req_valid_i), .req_op_i(d_req_op_i), .addr_i(d_addr_i),
        .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i),
        .req_ready_o(d_req_ready_o), .resp_valid_o(d_resp_valid_o), .rdata_o(d_rdata_o),
        .wb_cyc_o(dc_cyc), .wb_stb_o(dc_stb), .wb_we_o(dc_we), .wb_adr_o(dc_adr),
        .wb_dat_o(dc_dat_w), .wb_sel_o(dc_sel), .wb_ack_i(dc_ack), .wb_dat_i(dc_dat_r)
    );

    // icache is m0, reads whole words only
    wb_arbiter u_wb_arbiter (
        .clk, .reset_i,
        .m0_cyc_i(ic_cyc), .m0_stb_i(ic_stb), .m0_we_i(1'b0), .m0_adr_i(ic_adr),
        .m0_dat_i('0), .m0_sel_i('1), .m0_ack_o(ic_ack), .m0_dat_o(ic_dat_r),
        .m1_cyc_i(dc_cyc), .m1_stb_i(dc_stb), .m1_we_i(dc_we), .m1_adr_i(dc_adr),
        .m1_dat_i(dc_dat_w), .m1_sel_i(dc_sel), .m1_ack_o(dc_ack), .m1_dat_o(dc_dat_r),
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_sel_o,
        .wb_ack_i, .wb_dat_i
    );

endmodule

// ==== verification/cache_checker.sv ====
// watches both pipeline ports and the bus; fetch range below 0x1000, data range 0x1000 to 0x1FFF
module cache_checker (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               expect_hit_i,      // next accepted request must hit
    input  logic               expect_refill_i,   // next accepted request must refill
    input  logic               i_req_valid_i,
    input  cache_pkg::mem_op_e i_req_op_i,
    input  logic [31:0]        i_addr_i,
    input  logic               i_req_ready_i,
    input  logic               i_resp_valid_i,
    input  logic [31:0]        i_rdata_i,
    input  logic               d_req_valid_i,
    input  cache_pkg::mem_op_e d_req_op_i,
    input  logic [31:0]        d_addr_i,
    input  logic [31:0]        d_wdata_i,
    input  logic [3:0]         d_wstrb_i,
    input  logic               d_req_ready_i,
    input  logic               d_resp_valid_i,
    input  logic [31:0]        d_rdata_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [31:0]        wb_adr_i,
    input  logic [31:0]        wb_dat_i,
    input  logic [3:0]         wb_sel_i,
    input  logic               wb_ack_i,
    output int                 errors_o,
    output int                 writes_left_o
);
    import cache_pkg::*;

    logic [31:0] model [2048];
    logic [31:0] wq_adr [$];
    logic [31:0] wq_dat [$];
    logic [3:0]  wq_sel [$];
    logic [31:0] i_exp, d_exp, w_adr, w_dat;
    logic [3:0]  w_sel;
    bit i_busy, d_busy, i_hit, d_hit, i_refill, d_refill;
    bit cyc_q, burst_we, burst_side;
    int i_lat, d_lat, i_bursts, d_bursts, i_snap, d_snap, beats;

    function automatic logic [31:0] rule_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    initial begin
        for (int k = 0; k < 2048; k++) model[k] = rule_word(k * 4);
        errors_o = 0;
        writes_left_o = 0;
        i_bursts = 0;
        d_bursts = 0;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            i_busy = 0;
            d_busy = 0;
            cyc_q  = 0;
        end else begin
            // bus side first so a refill ending at this edge is counted
            if (wb_cyc_i && !cyc_q) begin
                burst_side = wb_adr_i[12];   // data range has bit 12 set
                burst_we   = wb_we_i;
                beats      = 0;
            end
            if (wb_cyc_i && cyc_q && wb_adr_i[12] != burst_side) begin
                errors_o++;
                $display("bus switched master while cyc was high at %0t", $time);
            end
            if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
                if (burst_we && wq_adr.size() == 0) begin
                    errors_o++;
                    $display("bus write at %0t had no matching request", $time);
                end else if (burst_we) begin
                    w_adr = wq_adr.pop_front();
                    w_dat = wq_dat.pop_front();
                    w_sel = wq_sel.pop_front();
                    if (wb_adr_i !== w_adr || wb_dat_i !== w_dat || wb_sel_i !== w_sel) begin
                        errors_o++;
                        $display("Error at %0t: bus write expected %h %h %h got %h %h %h",
                                 $time, w_adr, w_dat, w_sel, wb_adr_i, wb_dat_i, wb_sel_i);
                    end
                end else if (wb_adr_i[3:2] != beats[1:0]) begin
                    errors_o++;
                    $display("Error at %0t: refill word expected %0d got %0d",
                             $time, beats, wb_adr_i[3:2]);
                end
                beats++;
            end
            if (cyc_q && !wb_cyc_i) begin
                if (beats != (burst_we ? 1 : 4)) begin
                    errors_o++;
                    $display("bus cycle ending at %0t had %0d transfers", $time, beats);
                end
                if (burst_side) d_bursts++;
                else i_bursts++;
            end
            cyc_q = wb_cyc_i;

            if (i_busy) begin
                i_lat++;
                if (i_req_ready_i) begin
                    errors_o++;
                    $display("fetch port was ready before its response at %0t", $time);
                end
                if (i_resp_valid_i) begin
                    i_busy = 0;
                    if (i_rdata_i !== i_exp) begin
                        errors_o++;
                        $display("Error at %0t: fetch expected %h got %h",
                                 $time, i_exp, i_rdata_i);
                    end
                    if (i_hit && (i_lat != 1 || i_bursts != i_snap)) begin
                        errors_o++;
                        $display("fetch hit took %0d cycles or used the bus", i_lat);
                    end
                    if (i_refill && i_bursts != i_snap + 1) begin
                        errors_o++;
                        $display("fetch after invalidate did not refill the line");
                    end
                end
            end else if (i_resp_valid_i) begin
                errors_o++;
                $display("fetch response at %0t without a request", $time);
            end
            if (i_req_valid_i && i_req_ready_i) begin
                i_busy   = 1;
                i_lat    = 0;
                i_snap   = i_bursts;
                i_hit    = expect_hit_i;
                i_refill = expect_refill_i;
                i_exp    = (i_req_op_i == MEM_OP_INVAL) ? 32'h0 : rule_word(i_addr_i);
            end

            if (d_busy) begin
                d_lat++;
                if (d_req_ready_i) begin
                    errors_o++;
                    $display("data port was ready before its response at %0t", $time);
                end
                if (d_resp_valid_i) begin
                    d_busy = 0;
                    if (d_rdata_i !== d_exp) begin
                        errors_o++;
                        $display("Error at %0t: data expected %h got %h",
                                 $time, d_exp, d_rdata_i);
                    end
                    if (d_hit && (d_lat != 1 || d_bursts != d_snap)) begin
                        errors_o++;
                        $display("data hit took %0d cycles or used the bus", d_lat);
                    end
                    if (d_refill && d_bursts != d_snap + 1) begin
                        errors_o++;
                        $display("data read after invalidate did not refill the line");
                    end
                end
            end else if (d_resp_valid_i) begin
                errors_o++;
                $display("data response at %0t without a request", $time);
            end
            if (d_req_valid_i && d_req_ready_i) begin
                d_busy   = 1;
                d_lat    = 0;
                d_snap   = d_bursts;
                d_hit    = expect_hit_i;
                d_refill = expect_refill_i;
                d_exp    = 32'h0;
                if (d_req_op_i == MEM_OP_WRITE) begin
                    for (int b = 0; b < 4; b++) begin
                        if (d_wstrb_i[b]) model[d_addr_i[12:2]][8*b +: 8] = d_wdata_i[8*b +: 8];
                    end
                    wq_adr.push_back(d_addr_i);
                    wq_dat.push_back(d_wdata_i);
                    wq_sel.push_back(d_wstrb_i);
                end else if (d_req_op_i == MEM_OP_READ) begin
                    d_exp = model[d_addr_i[12:2]];
                end
            end
            writes_left_o = wq_adr.size();
        end
    end

endmodule

// ==== verification/tb_cache_top.sv ====
// drives both cache ports against a Wishbone memory of 8 KiB; fetch and data ranges kept apart
module tb_cache_top;
    import cache_pkg::*;

    localparam int SEED     = 32'h95c2_dd6b;
    localparam int N_FETCH  = 40;
    localparam int N_DATA   = 60;
    localparam int N_MIXED  = 30;
    localparam int TIMEOUT  = 200;

    logic clk, reset_i;
    logic i_req_valid, i_req_ready, i_resp_valid, d_req_valid, d_req_ready, d_resp_valid;
    mem_op_e i_req_op, d_req_op;
    logic [31:0] i_addr, i_rdata, d_addr, d_wdata, d_rdata;
    logic [3:0]  d_wstrb, wb_sel;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
    logic expect_hit, expect_refill;
    logic [31:0] mem [2048];
    logic [31:0] fa [N_MIXED];
    logic [31:0] da [N_MIXED];
    logic [31:0] dw [N_MIXED];
    int seed, ack_seed, delay_left, timeouts, last_fails, errors, writes_left;

    initial begin
        clk = 0;
        forever #20 clk = ~clk;
    end

    cache_top u_cache_top (
        .clk, .reset_i,
        .i_req_valid_i(i_req_valid), .i_req_op_i(i_req_op), .i_addr_i(i_addr),
        .i_req_ready_o(i_req_ready), .i_resp_valid_o(i_resp_valid), .i_rdata_o(i_rdata),
        .d_req_valid_i(d_req_valid), .d_req_op_i(d_req_op), .d_addr_i(d_addr),
        .d_wdata_i(d_wdata), .d_wstrb_i(d_wstrb),
        .d_req_ready_o(d_req_ready), .d_resp_valid_o(d_resp_valid), .d_rdata_o(d_rdata),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r)
    );

    cache_checker u_cache_checker (
        .clk, .reset_i, .expect_hit_i(expect_hit), .expect_refill_i(expect_refill),
        .i_req_valid_i(i_req_valid), .i_req_op_i(i_req_op), .i_addr_i(i_addr),
        .i_req_ready_i(i_req_ready), .i_resp_valid_i(i_resp_valid), .i_rdata_i(i_rdata),
        .d_req_valid_i(d_req_valid), .d_req_op_i(d_req_op), .d_addr_i(d_addr),
        .d_wdata_i(d_wdata), .d_wstrb_i(d_wstrb),
        .d_req_ready_i(d_req_ready), .d_resp_valid_i(d_resp_valid), .d_rdata_i(d_rdata),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_ack_i(wb_ack),
        .errors_o(errors), .writes_left_o(writes_left)
    );

    // memory slave, 0 to 3 wait cycles before each ack
    initial begin
        for (int k = 0; k < 2048; k++) mem[k] = (k * 4) ^ 32'h5a5a_0000;
        wb_ack = 0;
        wb_dat_r = '0;
        delay_left = -1;
        forever begin
            @(posedge clk);
            #5;
            if (wb_ack) begin
                wb_ack = 0;   // one-cycle pulse
            end else if (wb_cyc && wb_stb) begin
                if (delay_left < 0) delay_left = {$random(ack_seed)} % 4;
                if (delay_left == 0) begin
                    wb_ack = 1;
                    wb_dat_r = mem[wb_adr[12:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (wb_we && wb_sel[b]) mem[wb_adr[12:2]][8*b +: 8] = wb_dat_w[8*b +: 8];
                    end
                end
                delay_left--;
            end
        end
    end

    function automatic logic [31:0] rand_fetch_addr();
        return ({$random(seed)} % 1024) * 4;
    endfunction

    function automatic logic [31:0] rand_data_addr();
        return 32'h1000 + ({$random(seed)} % 1024) * 4;
    endfunction

    task automatic fetch(input mem_op_e op, input logic [31:0] a);
        int n;
        i_req_valid = 1;
        i_req_op = op;
        i_addr = a;
        n = 0;
        while (!i_req_ready && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!i_req_ready) begin
            timeouts++;
            $display("fetch port never became ready for %h", a);
        end
        @(posedge clk);
        #5;
        i_req_valid = 0;
        n = 0;
        while (!i_resp_valid && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!i_resp_valid) begin
            timeouts++;
            $display("fetch of %h never got a response", a);
        end
    endtask

    task automatic access(input mem_op_e op, input logic [31:0] a, input logic [31:0] wd,
                          input logic [3:0] ws);
        int n;
        d_req_valid = 1;
        d_req_op = op;
        d_addr = a;
        d_wdata = wd;
        d_wstrb = ws;
        n = 0;
        while (!d_req_ready && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!d_req_ready) begin
            timeouts++;
            $display("data port never became ready for %h", a);
        end
        @(posedge clk);
        #5;
        d_req_valid = 0;
        n = 0;
        while (!d_resp_valid && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!d_resp_valid) begin
            timeouts++;
            $display("data access to %h never got a response", a);
        end
    endtask

    task automatic random_access(input logic [31:0] a, input logic [31:0] w);
        if (w[0]) access(MEM_OP_WRITE, a, w, w[7:4]);
        else access(MEM_OP_READ, a, '0, '0);
    endtask

    task automatic end_test(input string name);
        @(posedge clk);   // checker compares a response on the edge after the port shows it
        #5;
        $display("%s: %0d failures", name, errors + timeouts - last_fails);
        last_fails = errors + timeouts;
    endtask

    initial begin
        seed = SEED;
        ack_seed = SEED + 1;
        timeouts = 0;
        last_fails = 0;
        expect_hit = 0;
        expect_refill = 0;
        i_req_valid = 0;
        i_req_op = MEM_OP_READ;
        i_addr = '0;
        d_req_valid = 0;
        d_req_op = MEM_OP_READ;
        d_addr = '0;
        d_wdata = '0;
        d_wstrb = '0;
        reset_i = 1;
        repeat (2) @(posedge clk);
        #5;
        reset_i = 0;

        repeat (N_FETCH) fetch(MEM_OP_READ, rand_fetch_addr());
        end_test("test 1 random fetch");
        repeat (N_DATA) random_access(rand_data_addr(), $random(seed));
        end_test("test 2 random data read and write");

        fetch(MEM_OP_READ, 32'h0200);
        access(MEM_OP_READ, 32'h1800, '0, '0);
        expect_hit = 1;
        fetch(MEM_OP_READ, 32'h0204);
        access(MEM_OP_READ, 32'h180c, '0, '0);
        expect_hit = 0;
        end_test("test 3 repeated read hits");

        fetch(MEM_OP_INVAL, 32'h0200);
        access(MEM_OP_INVAL, 32'h1800, '0, '0);
        expect_refill = 1;
        fetch(MEM_OP_READ, 32'h0208);
        access(MEM_OP_READ, 32'h1804, '0, '0);
        expect_refill = 0;
        end_test("test 4 invalidate then refill");

        fetch(MEM_OP_INVAL, 32'h0400);
        access(MEM_OP_INVAL, 32'h1400, '0, '0);
        fork
            fetch(MEM_OP_READ, 32'h0404);
            access(MEM_OP_READ, 32'h1408, '0, '0);
        join
        end_test("test 5 simultaneous misses");

        // drawn up front so both threads see a fixed sequence
        for (int k = 0; k < N_MIXED; k++) begin
            fa[k] = rand_fetch_addr();
            da[k] = rand_data_addr();
            dw[k] = $random(seed);
        end
        fork
            for (int k = 0; k < N_MIXED; k++) fetch(MEM_OP_READ, fa[k]);
            for (int k = 0; k < N_MIXED; k++) random_access(da[k], dw[k]);
        join
        end_test("test 6 concurrent traffic with random ack delay");

        if (writes_left != 0) begin
            timeouts++;
            $display("%0d data writes never reached the bus", writes_left);
        end
        $display("6 tests, %0d failures", errors + timeouts);
        if (errors + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/cache_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/wb_arbiter.sv
hw/cache_top.sv
verification/cache_checker.sv
verification/tb_cache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator; exit status follows the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module tb_cache_top -o sim_tb_cache_top
out=$(./obj_dir/sim_tb_cache_top)
echo "$out"
if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi
